// ==== logic/pmp_arch_pkg.sv ====
/*
 * PMP architectural encodings shared by the region logic
 * Configuration byte layout, region modes, privilege codes and widths
 */
package pmp_arch_pkg;

  ////////////////////////////////////////////////////////////
  // Address widths
  ////////////////////////////////////////////////////////////

  // Request address on both channels
  localparam int PhysAddrWidth = 32;

  // Region address in word units, upper bits beyond the CSR read as zero
  localparam int PmpAddrWidth = 34;

  ////////////////////////////////////////////////////////////
  // Configuration byte
  ////////////////////////////////////////////////////////////

  localparam int CfgBitR = 0;
  localparam int CfgBitW = 1;
  localparam int CfgBitX = 2;
  // Two bit address matching mode
  localparam int CfgModeLsb = 3;
  localparam int CfgBitL = 7;

  // Region address matching modes
  localparam logic [1:0] ModeOff   = 2'd0;
  localparam logic [1:0] ModeTor   = 2'd1;
  localparam logic [1:0] ModeNa4   = 2'd2;
  localparam logic [1:0] ModeNapot = 2'd3;

  ////////////////////////////////////////////////////////////
  // Privilege levels
  ////////////////////////////////////////////////////////////

  localparam logic [1:0] PrivUser    = 2'b00;
  localparam logic [1:0] PrivMachine = 2'b11;

endpackage

// ==== logic/pmp_csr_pkg.sv ====
/*
 * CSR map of the PMP block
 * Register numbers of the configuration and address CSRs, port widths
 */
package pmp_csr_pkg;

  // CSR port widths
  localparam int CsrNumWidth  = 12;
  localparam int CsrDataWidth = 32;

  // First configuration CSR, four configuration bytes per CSR
  // Region 4k+j sits in byte j of CSR k
  localparam logic [CsrNumWidth-1:0] CsrPmpCfgBase = 12'h3A0;

  // First address CSR, one CSR per region
  localparam logic [CsrNumWidth-1:0] CsrPmpAddrBase = 12'h3B0;

endpackage

// ==== logic/pmp_region_match.sv ====
/*
 * Address match and permission check of one PMP region
 * Serves the instruction and the data channel side by side
 */
`timescale 1ns/1ps

module pmp_region_match
  import pmp_arch_pkg::*;
(
  input  logic [7:0]               cfg_i,
  input  logic [PmpAddrWidth-1:0]  addr_i,
  input  logic [PmpAddrWidth-1:0]  prev_addr_i,

  input  logic [PhysAddrWidth-1:0] inst_addr_i,
  input  logic [PhysAddrWidth-1:0] data_addr_i,
  input  logic                     data_we_i,

  output logic                     inst_match_o,
  output logic                     inst_perm_ok_o,
  output logic                     data_match_o,
  output logic                     data_perm_ok_o
);

  logic [1:0]              mode;
  logic [PmpAddrWidth-1:0] napot_mask;
  logic [PmpAddrWidth-1:0] inst_word;
  logic [PmpAddrWidth-1:0] data_word;

  // Region test for one word address
  function automatic logic addr_hit(input logic [1:0]              mode_in,
                                    input logic [PmpAddrWidth-1:0] word,
                                    input logic [PmpAddrWidth-1:0] base,
                                    input logic [PmpAddrWidth-1:0] top,
                                    input logic [PmpAddrWidth-1:0] mask);
    logic hit;
    case (mode_in)
      ModeOff:   hit = 1'b0;
      // Top of range is exclusive
      ModeTor:   hit = (word >= base) && (word < top);
      ModeNa4:   hit = (word == top);
      ModeNapot: hit = ((word ^ top) & mask) == '0;
    endcase
    return hit;
  endfunction

  assign mode = cfg_i[CfgModeLsb +: 2];

  ////////////////////////////////////////////////////////////
  // NAPOT mask
  ////////////////////////////////////////////////////////////

  // k trailing ones leave the low k+1 word bits out of the compare
  always_comb begin
    napot_mask[0] = 1'b0;
    for (int j = 1; j < PmpAddrWidth; j++) begin
      napot_mask[j] = napot_mask[j-1] | ~addr_i[j-1];
    end
  end

  // Byte addresses to word units
  assign inst_word = {{(PmpAddrWidth-PhysAddrWidth+2){1'b0}}, inst_addr_i[PhysAddrWidth-1:2]};
  assign data_word = {{(PmpAddrWidth-PhysAddrWidth+2){1'b0}}, data_addr_i[PhysAddrWidth-1:2]};

  ////////////////////////////////////////////////////////////
  // Match and permissions
  ////////////////////////////////////////////////////////////

  assign inst_match_o = addr_hit(mode, inst_word, prev_addr_i, addr_i, napot_mask);
  assign data_match_o = addr_hit(mode, data_word, prev_addr_i, addr_i, napot_mask);

  // Fetch needs X, loads need R and stores need W
  assign inst_perm_ok_o = cfg_i[CfgBitX];
  assign data_perm_ok_o = data_we_i ? cfg_i[CfgBitW] : cfg_i[CfgBitR];

endmodule

// ==== logic/pmp_priority_resolve.sv ====
/*
 * PMP priority resolution
 * Lowest matching region decides the access error on each channel
 */
`timescale 1ns/1ps

module pmp_priority_resolve
  import pmp_arch_pkg::*;
#(
  parameter int unsigned NumRegions = 8
) (
  input  logic [NumRegions-1:0] inst_match_i,
  input  logic [NumRegions-1:0] inst_perm_ok_i,
  input  logic [NumRegions-1:0] data_match_i,
  input  logic [NumRegions-1:0] data_perm_ok_i,
  input  logic [NumRegions-1:0] region_lock_i,
  input  logic [1:0]            inst_priv_i,
  input  logic [1:0]            data_priv_i,
  output logic                  inst_err_o,
  output logic                  data_err_o
);

  function automatic logic chan_err(input logic [NumRegions-1:0] match,
                                    input logic [NumRegions-1:0] perm_ok,
                                    input logic [NumRegions-1:0] lock,
                                    input logic [1:0]            priv);
    logic err;
    logic is_user;
    is_user = (priv == PrivUser);
    // No match lets machine mode through and stops user mode
    err = is_user;
    // Walk down so the lowest matching region has the last word
    for (int i = NumRegions - 1; i >= 0; i--) begin
      if (match[i]) begin
        // Unlocked regions do not apply to machine mode
        err = (lock[i] || is_user) ? ~perm_ok[i] : 1'b0;
      end
    end
    return err;
  endfunction

  assign inst_err_o = chan_err(inst_match_i, inst_perm_ok_i, region_lock_i, inst_priv_i);
  assign data_err_o = chan_err(data_match_i, data_perm_ok_i, region_lock_i, data_priv_i);

endmodule

// ==== logic/pmp_csr_file.sv ====
/*
 * PMP configuration and address registers
 * Applies the WARL write rules and lock checks, muxes the CSR read data
 */
`timescale 1ns/1ps

module pmp_csr_file
  import pmp_arch_pkg::*;
  import pmp_csr_pkg::*;
#(
  parameter int unsigned NumRegions = 8
) (
  input  logic                                     clk,
  input  logic                                     rst_ni,

  // SRAM-like CSR port
  input  logic                                     csr_we_i,
  input  logic [CsrNumWidth-1:0]                   csr_addr_i,
  input  logic [CsrDataWidth-1:0]                  csr_wdata_i,
  output logic [CsrDataWidth-1:0]                  csr_rdata_o,
  output logic                                     csr_illegal_o,

  // Region state towards the match logic
  output logic [NumRegions-1:0][7:0]               region_cfg_o,
  output logic [NumRegions-1:0][PmpAddrWidth-1:0]  region_addr_o,
  output logic [NumRegions-1:0]                    region_lock_o
);

  localparam int unsigned NumCfgCsrs = NumRegions / 4;

  logic [CsrNumWidth-1:0] cfg_off;
  logic [CsrNumWidth-1:0] addr_off;
  logic                   cfg_valid;
  logic                   addr_valid;
  logic [NumRegions-1:0]  cfg_hit;
  logic [NumRegions-1:0]  addr_hit;
  logic [NumRegions-1:0]  tor_lock;
  logic [NumRegions-1:0]  addr_lock;

  ////////////////////////////////////////////////////////////
  // CSR number decode
  ////////////////////////////////////////////////////////////

  // Offsets below the base wrap around and fall out of range
  assign cfg_off    = csr_addr_i - CsrPmpCfgBase;
  assign addr_off   = csr_addr_i - CsrPmpAddrBase;
  assign cfg_valid  = cfg_off < CsrNumWidth'(NumCfgCsrs);
  assign addr_valid = addr_off < CsrNumWidth'(NumRegions);

  assign csr_illegal_o = ~(cfg_valid | addr_valid);

  // Address of region i is frozen by its own lock or a locked TOR region above it
  assign addr_lock = region_lock_o | (tor_lock >> 1);

  ////////////////////////////////////////////////////////////
  // Per region registers
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumRegions; i++) begin : g_region
    logic [7:0]              cfg_q;
    logic [CsrDataWidth-1:0] addr_q;
    logic [7:0]              cfg_raw;
    logic [7:0]              cfg_wdata;

    assign cfg_hit[i]  = cfg_valid & (cfg_off == CsrNumWidth'(i / 4));
    assign addr_hit[i] = addr_valid & (addr_off == CsrNumWidth'(i));

    assign cfg_raw = csr_wdata_i[8*(i%4) +: 8];

    // Reserved bits read as zero, W without R is not a legal combination
    always_comb begin
      cfg_wdata      = cfg_raw;
      cfg_wdata[6:5] = 2'b00;
      if (cfg_raw[CfgBitW] && !cfg_raw[CfgBitR]) begin
        cfg_wdata[CfgBitW] = 1'b0;
      end
    end

    always_ff @(posedge clk or negedge rst_ni) begin
      if (!rst_ni) begin
        cfg_q  <= '0;
        addr_q <= '0;
      end else begin
        if (csr_we_i && cfg_hit[i] && !cfg_q[CfgBitL]) begin
          cfg_q <= cfg_wdata;
        end
        if (csr_we_i && addr_hit[i] && !addr_lock[i]) begin
          addr_q <= csr_wdata_i;
        end
      end
    end

    assign region_cfg_o[i]  = cfg_q;
    assign region_addr_o[i] = {{(PmpAddrWidth-CsrDataWidth){1'b0}}, addr_q};
    assign region_lock_o[i] = cfg_q[CfgBitL];
    assign tor_lock[i]      = cfg_q[CfgBitL] & (cfg_q[CfgModeLsb +: 2] == ModeTor);
  end

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  // Illegal numbers hit nothing and read zero
  always_comb begin
    csr_rdata_o = '0;
    for (int i = 0; i < NumRegions; i++) begin
      if (cfg_hit[i]) begin
        csr_rdata_o[8*(i%4) +: 8] = region_cfg_o[i];
      end
      if (addr_hit[i]) begin
        csr_rdata_o = region_addr_o[i][CsrDataWidth-1:0];
      end
    end
  end

endmodule

// ==== logic/pmp_checker.sv ====
/*
 * PMP checker top level
 * Qualifies instruction and data requests against the PMP regions
 */
`timescale 1ns/1ps

module pmp_checker
  import pmp_arch_pkg::*;
  import pmp_csr_pkg::*;
#(
  parameter int unsigned NumRegions = 8
) (
  input  logic                     clk,
  input  logic                     rst_ni,

  // CSR port
  input  logic                     csr_we_i,
  input  logic [CsrNumWidth-1:0]   csr_addr_i,
  input  logic [CsrDataWidth-1:0]  csr_wdata_i,
  output logic [CsrDataWidth-1:0]  csr_rdata_o,
  output logic                     csr_illegal_o,

  // Instruction channel
  input  logic                     inst_req_i,
  input  logic [PhysAddrWidth-1:0] inst_addr_i,
  input  logic [1:0]               inst_priv_i,
  output logic                     inst_req_o,
  output logic                     inst_err_o,

  // Data channel
  input  logic                     data_req_i,
  input  logic [PhysAddrWidth-1:0] data_addr_i,
  input  logic                     data_we_i,
  input  logic [1:0]               data_priv_i,
  output logic                     data_req_o,
  output logic                     data_err_o
);

  logic [NumRegions-1:0][7:0]              region_cfg;
  logic [NumRegions-1:0][PmpAddrWidth-1:0] region_addr;
  logic [NumRegions-1:0]                   region_lock;
  logic [NumRegions-1:0]                   inst_match;
  logic [NumRegions-1:0]                   inst_perm_ok;
  logic [NumRegions-1:0]                   data_match;
  logic [NumRegions-1:0]                   data_perm_ok;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  pmp_csr_file #(
    .NumRegions    (NumRegions)
  ) csr_file_i (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .csr_we_i      (csr_we_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_rdata_o   (csr_rdata_o),
    .csr_illegal_o (csr_illegal_o),
    .region_cfg_o  (region_cfg),
    .region_addr_o (region_addr),
    .region_lock_o (region_lock)
  );

  ////////////////////////////////////////////////////////////
  // Region checks
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumRegions; i++) begin : g_region
    logic [PmpAddrWidth-1:0] prev_addr;

    // TOR base comes from the region below, zero for region 0
    if (i == 0) begin : g_first
      assign prev_addr = '0;
    end else begin : g_next
      assign prev_addr = region_addr[i-1];
    end

    pmp_region_match region_match_i (
      .cfg_i          (region_cfg[i]),
      .addr_i         (region_addr[i]),
      .prev_addr_i    (prev_addr),
      .inst_addr_i    (inst_addr_i),
      .data_addr_i    (data_addr_i),
      .data_we_i      (data_we_i),
      .inst_match_o   (inst_match[i]),
      .inst_perm_ok_o (inst_perm_ok[i]),
      .data_match_o   (data_match[i]),
      .data_perm_ok_o (data_perm_ok[i])
    );
  end

  pmp_priority_resolve #(
    .NumRegions     (NumRegions)
  ) priority_resolve_i (
    .inst_match_i   (inst_match),
    .inst_perm_ok_i (inst_perm_ok),
    .data_match_i   (data_match),
    .data_perm_ok_i (data_perm_ok),
    .region_lock_i  (region_lock),
    .inst_priv_i    (inst_priv_i),
    .data_priv_i    (data_priv_i),
    .inst_err_o     (inst_err_o),
    .data_err_o     (data_err_o)
  );

  // Requests leave only when no region denies them
  assign inst_req_o = inst_req_i & ~inst_err_o;
  assign data_req_o = data_req_i & ~data_err_o;

endmodule

// ==== bench/pmp_ref_model.svh ====
/*
 * Reference model of the PMP block
 * Mirrors the registers and predicts read data and access errors
 */
`ifndef PMP_REF_MODEL_SVH
`define PMP_REF_MODEL_SVH

logic [7:0]  ref_cfg  [NumRegions];
logic [31:0] ref_addr [NumRegions];

// Offset of a CSR number in a register range, -1 when outside
function automatic int csr_index(input logic [11:0] num, input logic [11:0] base,
                                 input int count);
  int off;
  off = int'(num) - int'(base);
  return (off >= 0 && off < count) ? off : -1;
endfunction

function automatic void clear_registers();
  for (int r = 0; r < NumRegions; r++) begin
    ref_cfg[r]  = '0;
    ref_addr[r] = '0;
  end
endfunction

function automatic void apply_csr_write(input logic [11:0] num, input logic [31:0] wdata);
  logic [7:0] b;
  logic       frozen;
  int         cfg_k;
  int         adr;
  cfg_k = csr_index(num, CsrPmpCfgBase, NumRegions / 4);
  adr   = csr_index(num, CsrPmpAddrBase, NumRegions);
  if (cfg_k >= 0) begin
    for (int j = 0; j < 4; j++) begin
      b      = wdata[8*j +: 8];
      b[6:5] = 2'b00;
      // Write only without read is turned into no access
      if (b[CfgBitW] && !b[CfgBitR]) begin
        b[CfgBitW] = 1'b0;
      end
      if (!ref_cfg[4*cfg_k + j][CfgBitL]) begin
        ref_cfg[4*cfg_k + j] = b;
      end
    end
  end else if (adr >= 0) begin
    frozen = ref_cfg[adr][CfgBitL];
    if (adr + 1 < NumRegions) begin
      frozen = frozen | (ref_cfg[adr+1][CfgBitL] && ref_cfg[adr+1][CfgModeLsb +: 2] == ModeTor);
    end
    if (!frozen) begin
      ref_addr[adr] = wdata;
    end
  end
endfunction

function automatic logic [31:0] expected_rdata(input logic [11:0] num);
  logic [31:0] rd;
  int          cfg_k;
  int          adr;
  rd    = '0;
  cfg_k = csr_index(num, CsrPmpCfgBase, NumRegions / 4);
  adr   = csr_index(num, CsrPmpAddrBase, NumRegions);
  if (cfg_k >= 0) begin
    for (int j = 0; j < 4; j++) begin
      rd[8*j +: 8] = ref_cfg[4*cfg_k + j];
    end
  end else if (adr >= 0) begin
    rd = ref_addr[adr];
  end
  return rd;
endfunction

function automatic logic region_hits(input int r, input logic [31:0] byte_addr);
  logic [63:0] word;
  logic [63:0] top;
  logic [63:0] lo;
  int          ones;
  logic        run;
  word = {32'b0, byte_addr} >> 2;
  top  = {32'b0, ref_addr[r]};
  ones = 0;
  run  = 1'b1;
  case (ref_cfg[r][CfgModeLsb +: 2])
    ModeTor: begin
      lo = (r == 0) ? 64'd0 : {32'b0, ref_addr[r-1]};
      return (word >= lo) && (word < top);
    end
    ModeNa4: return word == top;
    ModeNapot: begin
      // k trailing ones give a block of 2^(k+3) bytes
      for (int b = 0; b < 32; b++) begin
        run  = run & top[b];
        ones = ones + int'(run);
      end
      lo = (top >> (ones + 1)) << (ones + 3);
      return ({32'b0, byte_addr} >= lo) &&
             ({32'b0, byte_addr} < lo + (64'd1 << (ones + 3)));
    end
    default: return 1'b0;
  endcase
endfunction

function automatic logic expected_err(input logic [31:0] byte_addr, input logic [1:0] priv,
                                      input logic is_inst, input logic we);
  logic ok;
  for (int r = 0; r < NumRegions; r++) begin
    if (region_hits(r, byte_addr)) begin
      ok = is_inst ? ref_cfg[r][CfgBitX] : (we ? ref_cfg[r][CfgBitW] : ref_cfg[r][CfgBitR]);
      // Unlocked regions bind user mode only
      return (ref_cfg[r][CfgBitL] || priv == PrivUser) ? !ok : 1'b0;
    end
  end
  return priv == PrivUser;
endfunction

`endif

// ==== bench/pmp_checker_tb.sv ====
/*
 * Testbench of the PMP checker
 * Random CSR traffic and channel requests checked against a reference model
 */
`timescale 1ns/1ps

module pmp_checker_tb
  import pmp_arch_pkg::*;
  import pmp_csr_pkg::*;
();

  localparam int NumRegions     = 8;
  localparam int NumCsrs        = NumRegions / 4 + NumRegions;
  localparam int RstCycles      = 10;
  localparam int CsrWrites      = 150;
  localparam int Rounds         = 6;
  localparam int AccessPerRound = 40;
  localparam int LockAccesses   = 30;
  localparam int HoldCycles     = 40;
  localparam int PlannedCycles  = 3 * (RstCycles + 1) + 2 * CsrWrites + 2 * NumCsrs
                                  + Rounds * (NumCsrs + AccessPerRound)
                                  + LockAccesses + HoldCycles + 15;
  localparam int CycleLimit     = PlannedCycles + 100;

  logic        clk;
  logic        rst_ni;
  logic        csr_we_i;
  logic [11:0] csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic        csr_illegal_o;
  logic        inst_req_i;
  logic [31:0] inst_addr_i;
  logic [1:0]  inst_priv_i;
  logic        inst_req_o;
  logic        inst_err_o;
  logic        data_req_i;
  logic [31:0] data_addr_i;
  logic        data_we_i;
  logic [1:0]  data_priv_i;
  logic        data_req_o;
  logic        data_err_o;

  integer seed;
  int     errors;
  int     cycle_count;

  `include "pmp_ref_model.svh"

  pmp_checker #(
    .NumRegions (NumRegions)
  ) pmp_checker_i (
    .clk (clk), .rst_ni (rst_ni),
    .csr_we_i (csr_we_i), .csr_addr_i (csr_addr_i), .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o), .csr_illegal_o (csr_illegal_o),
    .inst_req_i (inst_req_i), .inst_addr_i (inst_addr_i), .inst_priv_i (inst_priv_i),
    .inst_req_o (inst_req_o), .inst_err_o (inst_err_o),
    .data_req_i (data_req_i), .data_addr_i (data_addr_i), .data_we_i (data_we_i),
    .data_priv_i (data_priv_i), .data_req_o (data_req_o), .data_err_o (data_err_o)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Cycle tasks
  ////////////////////////////////////////////////////////////

  task automatic start_cycle();
    @(posedge clk);
    #1;
    csr_we_i = 1'b0;
  endtask

  // Outputs settle well before the falling edge
  task automatic check_cycle();
    logic [31:0] exp_rdata;
    logic        exp_ill;
    logic        exp_ierr;
    logic        exp_derr;
    @(negedge clk);
    exp_rdata = expected_rdata(csr_addr_i);
    exp_ill   = csr_index(csr_addr_i, CsrPmpCfgBase, NumRegions / 4) < 0 &&
                csr_index(csr_addr_i, CsrPmpAddrBase, NumRegions) < 0;
    exp_ierr  = expected_err(inst_addr_i, inst_priv_i, 1'b1, 1'b0);
    exp_derr  = expected_err(data_addr_i, data_priv_i, 1'b0, data_we_i);
    assert (csr_rdata_o === exp_rdata && csr_illegal_o === exp_ill) else begin
      errors++;
      $display("[FAIL] %0t CSR %h read %h illegal %b, expected %h illegal %b", $time,
               csr_addr_i, csr_rdata_o, csr_illegal_o, exp_rdata, exp_ill);
    end
    assert (inst_err_o === exp_ierr && inst_req_o === (inst_req_i & ~exp_ierr)) else begin
      errors++;
      $display("[FAIL] %0t inst addr %h priv %0d err %b req %b, expected err %b", $time,
               inst_addr_i, inst_priv_i, inst_err_o, inst_req_o, exp_ierr);
    end
    assert (data_err_o === exp_derr && data_req_o === (data_req_i & ~exp_derr)) else begin
      errors++;
      $display("[FAIL] %0t data addr %h we %b priv %0d err %b req %b, expected err %b",
               $time, data_addr_i, data_we_i, data_priv_i, data_err_o, data_req_o, exp_derr);
    end
    // Model takes a write only after the compare
    if (csr_we_i) begin
      apply_csr_write(csr_addr_i, csr_wdata_i);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_ni   = 1'b0;
    csr_we_i = 1'b0;
    repeat (RstCycles) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    clear_registers();
  endtask

  task automatic csr_write(input logic [11:0] num, input logic [31:0] wdata);
    start_cycle();
    csr_we_i    = 1'b1;
    csr_addr_i  = num;
    csr_wdata_i = wdata;
    check_cycle();
  endtask

  task automatic csr_read(input logic [11:0] num);
    start_cycle();
    csr_addr_i = num;
    check_cycle();
  endtask

  task automatic read_all_csrs();
    for (int k = 0; k < NumRegions / 4; k++) begin
      csr_read(CsrPmpCfgBase + 12'(k));
    end
    for (int r = 0; r < NumRegions; r++) begin
      csr_read(CsrPmpAddrBase + 12'(r));
    end
  endtask

  // Mostly a few words around a region address
  task automatic pick_addr(output logic [31:0] a);
    int          r;
    logic [31:0] w;
    r = ($random(seed) & 32'h7fff_ffff) % NumRegions;
    if (($random(seed) & 3) == 0) begin
      a = $random(seed) & 32'h0000_1fff;
    end else begin
      w = ref_addr[r] + 32'($random(seed) & 7) - 32'd4;
      a = {w[29:0], 2'($random(seed))};
    end
  endtask

  task automatic set_access(input logic hold_req, input logic [1:0] priv, input logic mix);
    pick_addr(inst_addr_i);
    pick_addr(data_addr_i);
    inst_req_i = hold_req | 1'($random(seed));
    data_req_i = hold_req | 1'($random(seed));
    data_we_i  = 1'($random(seed));
    inst_priv_i = priv;
    data_priv_i = priv;
    if (mix) begin
      inst_priv_i = 1'($random(seed)) ? PrivMachine : PrivUser;
      data_priv_i = 1'($random(seed)) ? PrivMachine : PrivUser;
    end
  endtask

  task automatic access_cycle(input logic hold_req, input logic [1:0] priv, input logic mix);
    start_cycle();
    set_access(hold_req, priv, mix);
    check_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [11:0] num;
    seed        = 32'he580;
    errors      = 0;
    cycle_count = 0;
    clk         = 1'b0;
    rst_ni      = 1'b0;
    csr_we_i    = 1'b0;
    csr_addr_i  = '0;
    csr_wdata_i = '0;
    inst_req_i  = 1'b0;
    inst_addr_i = '0;
    inst_priv_i = PrivMachine;
    data_req_i  = 1'b0;
    data_addr_i = '0;
    data_we_i   = 1'b0;
    data_priv_i = PrivMachine;
    apply_reset();

    // Reset state with all regions off
    read_all_csrs();
    access_cycle(1'b1, PrivMachine, 1'b0);
    access_cycle(1'b1, PrivUser, 1'b0);
    start_cycle();
    inst_req_i = 1'b0;
    data_req_i = 1'b0;
    check_cycle();

    // Random CSR traffic to legal and illegal numbers
    repeat (CsrWrites) begin
      num = (($random(seed) & 7) == 0) ? 12'($random(seed))
                                       : CsrPmpCfgBase + 12'($random(seed) & 31);
      csr_write(num, $random(seed));
      csr_read(num);
    end

    // Random unlocked regions against user mode requests
    apply_reset();
    repeat (Rounds) begin
      for (int k = 0; k < NumRegions / 4; k++) begin
        csr_write(CsrPmpCfgBase + 12'(k), $random(seed) & 32'h7f7f_7f7f);
      end
      for (int r = 0; r < NumRegions; r++) begin
        csr_write(CsrPmpAddrBase + 12'(r), 32'(r * 32) + ($random(seed) & 32'h3f));
      end
      repeat (AccessPerRound) access_cycle(1'b0, PrivUser, 1'b0);
    end

    // Region 2 locked TOR read only
    // Region 5 locked NA4 execute only
    apply_reset();
    csr_write(CsrPmpAddrBase + 12'd1, 32'h100);
    csr_write(CsrPmpAddrBase + 12'd2, 32'h140);
    csr_write(CsrPmpAddrBase + 12'd5, 32'h200);
    csr_write(CsrPmpCfgBase, 32'h0089_0000);
    csr_write(CsrPmpCfgBase + 12'd1, 32'h0000_9400);
    // Attempts on locked entries
    csr_write(CsrPmpCfgBase, 32'h001f_0000);
    csr_write(CsrPmpCfgBase + 12'd1, 32'h0000_1f00);
    csr_write(CsrPmpAddrBase + 12'd2, 32'h999);
    csr_write(CsrPmpAddrBase + 12'd1, 32'h777);
    csr_write(CsrPmpAddrBase + 12'd5, 32'h555);
    csr_write(CsrPmpAddrBase + 12'd4, 32'h444);
    read_all_csrs();
    repeat (LockAccesses) access_cycle(1'b0, PrivMachine, 1'b0);

    // Held requests while region 4 becomes TOR read and execute halfway
    repeat (HoldCycles / 2) access_cycle(1'b1, PrivUser, 1'b1);
    start_cycle();
    set_access(1'b1, PrivUser, 1'b1);
    csr_we_i    = 1'b1;
    csr_addr_i  = CsrPmpCfgBase + 12'd1;
    csr_wdata_i = 32'h0000_000d;
    check_cycle();
    repeat (HoldCycles / 2) access_cycle(1'b1, PrivUser, 1'b1);

    $display("Checks failed: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+bench
logic/pmp_arch_pkg.sv
logic/pmp_csr_pkg.sv
logic/pmp_region_match.sv
logic/pmp_priority_resolve.sv
logic/pmp_csr_file.sv
logic/pmp_checker.sv
bench/pmp_checker_tb.sv

// ==== Makefile ====
TOP = pmp_checker_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir $(LOG)
